// File: files.f
src/eth_types_pkg.sv
src/eth_frame_pkg.sv
src/eth_crc32.sv
src/eth_tx_framer.sv
src/eth_rx_parser.sv
src/eth_frame_fifo.sv
src/eth_mac_top.sv
tests/eth_mac_checker.sv
tests/eth_mac_tb.sv

// File: src/eth_crc32.sv
`timescale 1ns/1ns
`default_nettype none

module eth_crc32 (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        enable,
    input  logic [7:0]  data,
    output logic [31:0] crc
);
    import eth_frame_pkg::*;

    // Eight LSB-first steps of the reflected polynomial
    function automatic logic [31:0] crc_next(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ crc_poly;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            crc <= crc_init;
        end else if (enable) begin
            crc <= crc_next(crc, data);
        end
    end

endmodule

`default_nettype wire

// File: src/eth_frame_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module eth_frame_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  eth_types_pkg::stream_byte_t wr_data,
    input  logic                        wr_en,
    input  logic                        commit,
    input  logic                        drop,
    output eth_types_pkg::stream_byte_t rx_out,
    output logic                        rx_valid,
    input  logic                        rx_ready
);
    import eth_types_pkg::*;
    import eth_frame_pkg::*;

    stream_byte_t           mem [fifo_depth];
    logic [fifo_addr_w:0]   wr_ptr;
    logic [fifo_addr_w:0]   wr_ptr_next;
    logic [fifo_addr_w:0]   commit_ptr;
    logic [fifo_addr_w:0]   rd_ptr;
    logic                   full;
    logic                   overflow;
    logic                   wr_ok;
    logic                   load;

    // Extra pointer bit tells full from empty
    assign full = (wr_ptr[fifo_addr_w] != rd_ptr[fifo_addr_w])
               && (wr_ptr[fifo_addr_w-1:0] == rd_ptr[fifo_addr_w-1:0]);

    assign wr_ok       = wr_en && !full && !overflow;
    assign wr_ptr_next = wr_ptr + (fifo_addr_w + 1)'(wr_ok);

    // Read side sees committed bytes only
    assign load = (rd_ptr != commit_ptr) && (!rx_valid || rx_ready);

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[fifo_addr_w-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            overflow   <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr_next;
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
            // A frame that overflowed is discarded whole
            if (drop || (commit && (overflow || (wr_en && full)))) begin
                wr_ptr   <= commit_ptr;
                overflow <= 1'b0;
            end else if (commit) begin
                commit_ptr <= wr_ptr_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr   <= '0;
            rx_valid <= 1'b0;
        end else if (load) begin
            rd_ptr   <= rd_ptr + 1'b1;
            rx_valid <= 1'b1;
        end else if (rx_ready) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rx_out <= mem[rd_ptr[fifo_addr_w-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: src/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

    // Preamble and start-of-frame delimiter
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hD5;
    localparam int         preamble_len  = 7;

    // Shortest frame before the FCS
    localparam int min_payload_len = 60;
    localparam int ifg_len         = 12;

    // Reflected CRC-32 as used for the Ethernet FCS
    localparam logic [31:0] crc_poly    = 32'hEDB8_8320;
    localparam logic [31:0] crc_init    = 32'hFFFF_FFFF;
    localparam logic [31:0] crc_residue = 32'hDEBB_20E3;

    // Receive frame buffer
    localparam int fifo_depth  = 2048;
    localparam int fifo_addr_w = 11;

endpackage

`default_nettype wire

// File: src/eth_mac_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_mac_top (
    input  logic                        clk,
    input  logic                        reset,
    input  eth_types_pkg::stream_byte_t tx_in,
    input  logic                        tx_valid,
    output logic                        tx_ready,
    output eth_types_pkg::gmii_t        gmii_tx,
    input  eth_types_pkg::gmii_t        gmii_rx,
    output eth_types_pkg::stream_byte_t rx_out,
    output logic                        rx_valid,
    input  logic                        rx_ready
);
    import eth_types_pkg::*;

    // Parser to frame FIFO
    stream_byte_t wr_data;
    logic         wr_en;
    logic         commit;
    logic         drop;

    eth_tx_framer eth_tx_framer_i (
        .clk      (clk),
        .reset    (reset),
        .tx_in    (tx_in),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .gmii_tx  (gmii_tx)
    );

    eth_rx_parser eth_rx_parser_i (
        .clk     (clk),
        .reset   (reset),
        .gmii_rx (gmii_rx),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .commit  (commit),
        .drop    (drop)
    );

    eth_frame_fifo eth_frame_fifo_i (
        .clk      (clk),
        .reset    (reset),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .commit   (commit),
        .drop     (drop),
        .rx_out   (rx_out),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

endmodule

`default_nettype wire

// File: src/eth_rx_parser.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_parser (
    input  logic                        clk,
    input  logic                        reset,
    input  eth_types_pkg::gmii_t        gmii_rx,
    output eth_types_pkg::stream_byte_t wr_data,
    output logic                        wr_en,
    output logic                        commit,
    output logic                        drop
);
    import eth_frame_pkg::*;

    logic            in_frame;
    logic            pre_seen;
    logic            err;
    logic [4:0][7:0] dly;
    logic [4:0]      dly_v;
    logic [31:0]     crc;
    logic            crc_ok;

    // Runs over every byte after the delimiter, FCS included
    eth_crc32 crc_i (
        .clk    (clk),
        .reset  (reset),
        .clear  (!in_frame),
        .enable (in_frame && gmii_rx.en),
        .data   (gmii_rx.d),
        .crc    (crc)
    );

    // The oldest stage leaves once four newer bytes sit behind it,
    // so the FCS never reaches the FIFO
    assign wr_en   = in_frame && dly_v[4];
    assign wr_data = '{data: dly[4], last: !gmii_rx.en};

    assign crc_ok = (crc == crc_residue) && !err;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame <= 1'b0;
            pre_seen <= 1'b0;
            err      <= 1'b0;
            dly_v    <= '0;
            commit   <= 1'b0;
            drop     <= 1'b0;
        end else begin
            commit <= 1'b0;
            drop   <= 1'b0;
            // Remembers er for the rest of the run
            err    <= gmii_rx.en && (err || gmii_rx.er);
            if (!in_frame) begin
                pre_seen <= gmii_rx.en && (gmii_rx.d == preamble_byte);
                if (gmii_rx.en && pre_seen && (gmii_rx.d == sfd_byte)) begin
                    in_frame <= 1'b1;
                    dly_v    <= '0;
                end
            end else if (gmii_rx.en) begin
                dly_v <= {dly_v[3:0], 1'b1};
            end else begin
                // End of run gives the verdict
                in_frame <= 1'b0;
                commit   <= crc_ok;
                drop     <= !crc_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_frame && gmii_rx.en) begin
            dly <= {dly[3:0], gmii_rx.d};
        end
    end

endmodule

`default_nettype wire

// File: src/eth_tx_framer.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_framer (
    input  logic                        clk,
    input  logic                        reset,
    input  eth_types_pkg::stream_byte_t tx_in,
    input  logic                        tx_valid,
    output logic                        tx_ready,
    output eth_types_pkg::gmii_t        gmii_tx
);
    import eth_frame_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_delimiter,
        st_payload,
        st_pad,
        st_fcs,
        st_gap
    } state_t;

    state_t      state;
    logic [3:0]  cnt;
    logic [15:0] len_cnt;
    logic        xfer;
    logic        crc_en;
    logic [7:0]  crc_data;
    logic [31:0] crc;

    // Source is accepted only while the delimiter or payload is on the wire
    assign tx_ready = (state == st_delimiter) || (state == st_payload);
    assign xfer     = tx_ready && tx_valid;

    // Payload and zero padding both feed the CRC
    assign crc_en   = xfer || (state == st_pad);
    assign crc_data = xfer ? tx_in.data : 8'h00;

    eth_crc32 crc_i (
        .clk    (clk),
        .reset  (reset),
        .clear  (state == st_idle),
        .enable (crc_en),
        .data   (crc_data),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            cnt     <= '0;
            len_cnt <= '0;
            gmii_tx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    gmii_tx <= '0;
                    if (tx_valid) begin
                        gmii_tx <= '{d: preamble_byte, en: 1'b1, er: 1'b0};
                        cnt     <= 4'd1;
                        state   <= st_preamble;
                    end
                end
                st_preamble: begin
                    if (cnt == 4'(preamble_len)) begin
                        gmii_tx.d <= sfd_byte;
                        len_cnt   <= '0;
                        state     <= st_delimiter;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                st_delimiter, st_payload: begin
                    if (xfer) begin
                        gmii_tx.d <= tx_in.data;
                        len_cnt   <= len_cnt + 16'd1;
                        state     <= st_payload;
                        if (tx_in.last) begin
                            cnt <= '0;
                            if (len_cnt + 16'd1 < 16'(min_payload_len)) begin
                                state <= st_pad;
                            end else begin
                                state <= st_fcs;
                            end
                        end
                    end
                end
                st_pad: begin
                    gmii_tx.d <= 8'h00;
                    len_cnt   <= len_cnt + 16'd1;
                    if (len_cnt == 16'(min_payload_len - 1)) begin
                        state <= st_fcs;
                    end
                end
                st_fcs: begin
                    // Inverted register, low byte first
                    gmii_tx.d <= ~crc[{cnt[1:0], 3'b000} +: 8];
                    cnt       <= cnt + 4'd1;
                    if (cnt == 4'd3) begin
                        cnt   <= '0;
                        state <= st_gap;
                    end
                end
                st_gap: begin
                    gmii_tx <= '0;
                    cnt     <= cnt + 4'd1;
                    if (cnt == 4'(ifg_len - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/eth_types_pkg.sv
`default_nettype none

package eth_types_pkg;

    // One byte of a frame stream
    // The last bit flags the final byte of the frame
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } stream_byte_t;

    // GMII byte lane, one byte per clock
    typedef struct packed {
        logic [7:0] d;
        logic       en;
        logic       er;
    } gmii_t;

endpackage

`default_nettype wire

// File: tests/eth_mac_checker.sv
`timescale 1ns/1ns
`default_nettype none

module eth_mac_checker (
    input logic                        clk,
    input logic                        reset,
    input eth_types_pkg::stream_byte_t tx_in,
    input logic                        tx_valid,
    input logic                        tx_ready,
    input eth_types_pkg::gmii_t        gmii_tx,
    input eth_types_pkg::stream_byte_t rx_out,
    input logic                        rx_valid,
    input logic                        rx_ready
);
    int   fail_count = 0;
    logic tx_open;

    // High between the first and the last transfer of a transmit frame
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_open <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            tx_open <= !tx_in.last;
        end
    end

    reset_outputs_low: assert property (@(posedge clk)
        reset |=> !tx_ready && !gmii_tx.en && !rx_valid)
        else begin
            $error("tx_ready, gmii_tx.en or rx_valid high after reset");
            fail_count++;
        end

    tx_valid_held: assert property (@(posedge clk) disable iff (reset)
        tx_open |-> tx_valid)
        else begin
            $error("tx_valid fell inside a transmit frame");
            fail_count++;
        end

    rx_held_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_out))
        else begin
            $error("rx_out or rx_valid changed while rx_ready was low");
            fail_count++;
        end

    gmii_er_low: assert property (@(posedge clk) disable iff (reset)
        !gmii_tx.er)
        else begin
            $error("gmii_tx.er went high");
            fail_count++;
        end

endmodule

bind eth_mac_top eth_mac_checker eth_mac_checker_i (
    .clk      (clk),
    .reset    (reset),
    .tx_in    (tx_in),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .gmii_tx  (gmii_tx),
    .rx_out   (rx_out),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready)
);

`default_nettype wire

// File: tests/eth_mac_tb.sv
`timescale 1ns/1ns
`default_nettype none

module eth_mac_tb;
    import eth_types_pkg::*;
    import eth_frame_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    // Summed frame lengths of all tests with loopback at its longest
    localparam int timeout_cycles = 20 * (64 + 20 + 46 + 40 + 30 + 70 + 100 + 75 + 120 + 100);

    logic         clk = 1'b0;
    logic         reset;
    stream_byte_t tx_in;
    logic         tx_valid;
    logic         tx_ready;
    gmii_t        gmii_tx;
    gmii_t        gmii_rx;
    stream_byte_t rx_out;
    logic         rx_valid;
    logic         rx_ready;

    integer       seed = 32'h0447_107a;
    logic [31:0]  bp_rand;
    logic         bp_on;
    logic         loopback;
    int           value_errors = 0;
    int           other_errors = 0;
    int           assert_errors;
    stream_byte_t rx_q [$];
    stream_byte_t exp_q [$];

    eth_mac_top eth_mac_top_i (
        .clk      (clk),
        .reset    (reset),
        .tx_in    (tx_in),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .gmii_tx  (gmii_tx),
        .gmii_rx  (gmii_rx),
        .rx_out   (rx_out),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

    always #4 clk = ~clk;

    // Sampled half a cycle ahead of the edge that transfers the byte
    always @(negedge clk) begin
        if (!reset && rx_valid && rx_ready) begin
            rx_q.push_back(rx_out);
        end
    end

    always @(posedge clk) begin
        if (bp_on) begin
            bp_rand = $random(seed);
            rx_ready <= bp_rand[0];
        end else begin
            rx_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (loopback) begin
            gmii_rx <= gmii_tx;
        end
    end

    // Bitwise reflected CRC-32 returned already inverted
    function automatic logic [31:0] fcs_of(input byte_q_t bytes);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        foreach (bytes[k]) begin
            for (int b = 0; b < 8; b++) begin
                c = {1'b0, c[31:1]} ^ ((c[0] ^ bytes[k][b]) ? 32'hEDB8_8320 : 32'h0);
            end
        end
        return ~c;
    endfunction

    function automatic byte_q_t random_payload(input int len);
        byte_q_t p;
        for (int k = 0; k < len; k++) begin
            p.push_back(8'($random(seed)));
        end
        return p;
    endfunction

    function automatic byte_q_t pad_to_minimum(input byte_q_t p);
        byte_q_t q;
        q = p;
        while (q.size() < min_payload_len) begin
            q.push_back(8'h00);
        end
        return q;
    endfunction

    // Preamble, delimiter, body and FCS low byte first
    function automatic byte_q_t wire_image(input byte_q_t body);
        byte_q_t     line_q;
        logic [31:0] fcs;
        fcs = fcs_of(body);
        for (int k = 0; k < preamble_len; k++) begin
            line_q.push_back(preamble_byte);
        end
        line_q.push_back(sfd_byte);
        foreach (body[k]) begin
            line_q.push_back(body[k]);
        end
        for (int k = 0; k < 4; k++) begin
            line_q.push_back(fcs[8*k +: 8]);
        end
        return line_q;
    endfunction

    task automatic check_byte(input string name, input stream_byte_t exp, input stream_byte_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_gmii(input string name, input gmii_t exp, input gmii_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic send_tx(input byte_q_t p);
        int   i;
        logic ready_seen;
        i = 0;
        @(posedge clk);
        tx_valid <= 1'b1;
        tx_in    <= '{data: p[0], last: p.size() == 1};
        while (i < p.size()) begin
            @(negedge clk);
            ready_seen = tx_ready;
            @(posedge clk);
            if (ready_seen) begin
                i++;
                if (i < p.size()) begin
                    tx_in <= '{data: p[i], last: i == p.size() - 1};
                end else begin
                    tx_valid <= 1'b0;
                    tx_in    <= '0;
                end
            end
        end
    endtask

    // En must stay high for exactly the frame, then low through the gap
    // Ready is high from the delimiter until the last byte is taken
    task automatic watch_tx(input byte_q_t p);
        byte_q_t line_q;
        gmii_t   lane;
        line_q = wire_image(pad_to_minimum(p));
        @(negedge clk);
        while (!gmii_tx.en) begin
            @(negedge clk);
        end
        foreach (line_q[k]) begin
            lane.d  = line_q[k];
            lane.en = 1'b1;
            lane.er = 1'b0;
            check_gmii("gmii_tx", lane, gmii_tx);
            check_ready("tx_ready", (k >= preamble_len) && (k < preamble_len + p.size()),
                        tx_ready);
            @(negedge clk);
        end
        repeat (ifg_len) begin
            check_gmii("gmii_tx", '0, gmii_tx);
            check_ready("tx_ready", 1'b0, tx_ready);
            @(negedge clk);
        end
    endtask

    task automatic drive_rx(input byte_q_t p, input logic bad_fcs, input logic raise_er);
        byte_q_t line_q;
        line_q = wire_image(p);
        if (bad_fcs) begin
            line_q[line_q.size() - 1] = line_q[line_q.size() - 1] ^ 8'h01;
        end
        foreach (line_q[k]) begin
            @(posedge clk);
            gmii_rx <= '{d: line_q[k], en: 1'b1, er: raise_er && (k == 12)};
        end
        @(posedge clk);
        gmii_rx <= '0;
        repeat (ifg_len - 1) @(posedge clk);
    endtask

    task automatic expect_frame(input byte_q_t p);
        stream_byte_t sb;
        foreach (p[k]) begin
            sb.data = p[k];
            sb.last = (k == p.size() - 1);
            exp_q.push_back(sb);
        end
    endtask

    task automatic compare_rx();
        stream_byte_t exp_b;
        stream_byte_t act_b;
        while (exp_q.size() > 0) begin
            while (rx_q.size() == 0) begin
                @(posedge clk);
            end
            exp_b = exp_q.pop_front();
            act_b = rx_q.pop_front();
            check_byte("rx_out", exp_b, act_b);
        end
    endtask

    task automatic transmit_frame(input int len);
        byte_q_t p;
        p = random_payload(len);
        fork
            send_tx(p);
            watch_tx(p);
        join
    endtask

    task automatic receive_good_frame();
        byte_q_t p;
        p = random_payload(46);
        expect_frame(p);
        drive_rx(p, 1'b0, 1'b0);
        compare_rx();
    endtask

    // Only the last of the three frames may reach rx_out
    task automatic reject_bad_frames();
        byte_q_t bad;
        byte_q_t errored;
        byte_q_t good;
        bad     = random_payload(40);
        errored = random_payload(30);
        good    = random_payload(70);
        drive_rx(bad, 1'b1, 1'b0);
        drive_rx(errored, 1'b0, 1'b1);
        drive_rx(good, 1'b0, 1'b0);
        expect_frame(good);
        compare_rx();
    endtask

    task automatic receive_under_backpressure();
        byte_q_t p;
        bp_on <= 1'b1;
        p = random_payload(100);
        expect_frame(p);
        drive_rx(p, 1'b0, 1'b0);
        p = random_payload(75);
        expect_frame(p);
        drive_rx(p, 1'b0, 1'b0);
        p = random_payload(120);
        expect_frame(p);
        drive_rx(p, 1'b0, 1'b0);
        compare_rx();
        bp_on <= 1'b0;
    endtask

    task automatic loop_frame_back();
        byte_q_t p;
        int      len;
        loopback <= 1'b1;
        len = 1 + ($unsigned($random(seed)) % 100);
        p = random_payload(len);
        expect_frame(pad_to_minimum(p));
        send_tx(p);
        compare_rx();
        loopback <= 1'b0;
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("The run timed out before all tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        tx_in    = '0;
        tx_valid = 1'b0;
        gmii_rx  = '0;
        rx_ready = 1'b1;
        bp_on    = 1'b0;
        loopback = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        transmit_frame(64);
        transmit_frame(20);
        receive_good_frame();
        reject_bad_frames();
        receive_under_backpressure();
        loop_frame_back();

        // Nothing more may arrive after the last expected frame
        repeat (50) @(posedge clk);
        if (rx_q.size() != 0) begin
            other_errors++;
            $display("%0d unexpected bytes were delivered at rx_out", rx_q.size());
        end
        assert_errors = eth_mac_top_i.eth_mac_checker_i.fail_count;
        $display("Error counts: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
